//--- source/mem_msg_pkg.sv
//----------------------------------------
// Message field widths, request type codes and
// partition constants shared by the test memory
//----------------------------------------
package mem_msg_pkg;

	//----------------------------------------
	// Message field widths
	//----------------------------------------

	// Request and response type field
	localparam int c_type_nbits = 3;
	// Opaque tag, echoed back untouched
	localparam int c_opaque_nbits = 8;
	localparam int c_addr_nbits = 32;
	// Byte length, zero stands for a full word
	localparam int c_len_nbits = 2;
	localparam int c_data_nbits = 32;

	// Byte offset bits within one data word
	localparam int c_off_nbits = $clog2(c_data_nbits / 8);

	// Request control is type, opaque, addr, len from the top down
	localparam int c_req_cnbits = c_type_nbits + c_opaque_nbits + c_addr_nbits + c_len_nbits;

	// Response control is type, opaque, len from the top down
	localparam int c_resp_cnbits = c_type_nbits + c_opaque_nbits + c_len_nbits;

	//----------------------------------------
	// Request type codes
	//----------------------------------------

	typedef enum logic [c_type_nbits-1:0] {
		mem_read       = 3'd0,
		mem_write      = 3'd1,
		mem_write_init = 3'd2,
		mem_amo_add    = 3'd3,
		mem_amo_and    = 3'd4,
		mem_amo_or     = 3'd5
	} mem_type_e;

	//----------------------------------------
	// Partition constants
	//----------------------------------------

	// Window number sits in addr[15:14], one window per 16 KiB
	localparam int c_window_lsb = 14;
	localparam int c_win_nbits = 2;

	// Window minus twice the mode gives the partition code
	localparam logic [c_win_nbits-1:0] c_part_public = 2'd0;
	localparam logic [c_win_nbits-1:0] c_part_secure = 2'd1;

endpackage

//--- source/mem_queue.sv
//----------------------------------------
// One-entry val/rdy queue, pipe or bypass form
// Pipe cuts the path enq to deq, bypass cuts deq_rdy to enq_rdy
//----------------------------------------
`timescale 1ns/1ns

module mem_queue #(
	parameter int p_msg_nbits = 32,
	parameter bit p_bypass = 1'b0
) (
	input  logic                   clk,
	input  logic                   reset,

	input  logic                   enq_val_i,
	output logic                   enq_rdy_o,
	input  logic [p_msg_nbits-1:0] enq_msg_i,

	output logic                   deq_val_o,
	input  logic                   deq_rdy_i,
	output logic [p_msg_nbits-1:0] deq_msg_o
);

	// Occupancy flag and the single stored message
	logic                   full;
	logic [p_msg_nbits-1:0] entry;

	logic enq_fire;
	logic deq_fire;
	// High when the incoming message has to be kept in the entry
	logic store;

	assign enq_fire = enq_val_i && enq_rdy_o;
	assign deq_fire = deq_val_o && deq_rdy_i;

	generate
		if (p_bypass) begin : g_bypass
			// Accept only into an empty entry
			assign enq_rdy_o = !full;
			// Empty queue hands the incoming message straight through
			assign deq_val_o = full || enq_val_i;
			assign deq_msg_o = full ? entry : enq_msg_i;
			// Keep it only when the consumer did not take it this cycle
			assign store = enq_fire && !deq_fire;
		end else begin : g_pipe
			// A full entry can be refilled while it drains
			assign enq_rdy_o = !full || deq_rdy_i;
			assign deq_val_o = full;
			assign deq_msg_o = entry;
			assign store = enq_fire;
		end
	endgenerate

	always_ff @(posedge clk) begin
		if (!reset) begin
			full <= 1'b0;
		end else if (store) begin
			full <= 1'b1;
		end else if (deq_fire) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (store) begin
			entry <= enq_msg_i;
		end
	end

endmodule

//--- source/mem_access_check.sv
//----------------------------------------
// Maps a request address, the mode and the domain to a
// partition, word index and byte offset, and grants access
//----------------------------------------
`timescale 1ns/1ns

module mem_access_check
	import mem_msg_pkg::*;
#(
	parameter int p_part_words = 256
) (
	input  logic [c_addr_nbits-1:0]         addr_i,
	input  logic                            mode_i,
	input  logic                            domain_i,

	output logic                            secure_o,
	output logic                            allow_o,
	output logic [$clog2(p_part_words)-1:0] word_idx_o,
	output logic [c_off_nbits-1:0]          byte_off_o
);

	// Word index bits, p_part_words is a power of two
	localparam int c_idx_nbits = $clog2(p_part_words);

	// Raw 16 KiB window number
	logic [c_win_nbits-1:0] window;
	// Window relative to the current mode
	logic [c_win_nbits-1:0] part;

	assign window = addr_i[c_window_lsb +: c_win_nbits];

	// Mode 1 moves both partitions up by two windows
	// Windows below the pair wrap round to 2 or 3 and fall out of range
	assign part = window - {mode_i, 1'b0};

	//----------------------------------------
	// Partition select and access rule
	//----------------------------------------

	assign secure_o = (part == c_part_secure);

	// Public accepts any domain
	// Secure only domain 1, out of range never
	assign allow_o = (part == c_part_public) || (secure_o && domain_i);

	//----------------------------------------
	// Word index and byte offset
	//----------------------------------------

	// Upper address bits wrap modulo the partition size
	assign word_idx_o = addr_i[c_off_nbits +: c_idx_nbits];
	assign byte_off_o = addr_i[c_off_nbits-1:0];

endmodule

//--- source/mem_partition_array.sv
//----------------------------------------
// Public and secure word storage with combinational read,
// byte-lane writes, atomics and a one-cycle clear
//----------------------------------------
`timescale 1ns/1ns

module mem_partition_array
	import mem_msg_pkg::*;
#(
	parameter int p_part_words = 256
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            clear_i,
	input  logic                            req_fire_i,

	input  mem_type_e                       type_i,
	input  logic [c_len_nbits-1:0]          len_i,
	input  logic [c_data_nbits-1:0]         data_i,
	input  logic                            secure_i,
	input  logic                            allow_i,
	input  logic [$clog2(p_part_words)-1:0] word_idx_i,
	input  logic [c_off_nbits-1:0]          byte_off_i,

	output logic [c_data_nbits-1:0]         rdata_o
);

	localparam int c_data_nbytes = c_data_nbits / 8;

	//----------------------------------------
	// Storage
	//----------------------------------------

	logic [c_data_nbits-1:0] pub_mem [p_part_words];
	logic [c_data_nbits-1:0] sec_mem [p_part_words];

	// Addressed word before any shift
	logic [c_data_nbits-1:0] old_word;
	// Old word aligned to the byte offset
	logic [c_data_nbits-1:0] old_shift;
	// Byte count with zero expanded to a full word
	logic [c_len_nbits:0]    len_bytes;
	logic [c_data_nbits-1:0] write_word;
	logic [c_data_nbits-1:0] amo_word;
	logic [c_data_nbits-1:0] next_word;

	logic is_write;
	logic is_amo;
	logic store_en;

	assign old_word = secure_i ? sec_mem[word_idx_i] : pub_mem[word_idx_i];
	assign old_shift = old_word >> {byte_off_i, 3'b000};

	// Denied or out-of-range reads give zero
	assign rdata_o = allow_i ? old_shift : '0;

	//----------------------------------------
	// Write merge
	//----------------------------------------

	assign len_bytes = (len_i == '0) ? (c_len_nbits + 1)'(c_data_nbytes) : {1'b0, len_i};

	// Source byte k lands in lane byte_off + k
	// Lanes past the top of the word are dropped
	always_comb begin
		int lane;
		write_word = old_word;
		for (int k = 0; k < c_data_nbytes; k++) begin
			lane = int'(byte_off_i) + k;
			if (k < int'(len_bytes) && lane < c_data_nbytes) begin
				write_word[8*lane +: 8] = data_i[8*k +: 8];
			end
		end
	end

	//----------------------------------------
	// Atomics
	//----------------------------------------

	// Combine with the shifted old word, the one sent back as the response
	always_comb begin
		case (type_i)
			mem_amo_add: amo_word = data_i + old_shift;
			mem_amo_and: amo_word = data_i & old_shift;
			mem_amo_or:  amo_word = data_i | old_shift;
			default:     amo_word = old_word;
		endcase
	end

	assign is_write = (type_i == mem_write) || (type_i == mem_write_init);
	assign is_amo = (type_i == mem_amo_add) || (type_i == mem_amo_and)
		|| (type_i == mem_amo_or);

	assign next_word = is_amo ? amo_word : write_word;

	// Only on the internal handshake, so each request acts once
	assign store_en = req_fire_i && allow_i && (is_write || is_amo);

	//----------------------------------------
	// Update
	//----------------------------------------

	// Clear wins over a write in the same cycle
	// No stores while reset is held
	always_ff @(posedge clk) begin
		if (clear_i) begin
			for (int i = 0; i < p_part_words; i++) begin
				pub_mem[i] <= '0;
				sec_mem[i] <= '0;
			end
		end else if (reset && store_en) begin
			if (secure_i) begin
				sec_mem[word_idx_i] <= next_word;
			end else begin
				pub_mem[word_idx_i] <= next_word;
			end
		end
	end

endmodule

//--- source/test_mem_uni.sv
//----------------------------------------
// Single-ported unified test memory, public and secure
// partitions behind a pipe request queue and bypass response queue
//----------------------------------------
`timescale 1ns/1ns

module test_mem_uni
	import mem_msg_pkg::*;
#(
	parameter int p_part_words = 256
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     mode_i,
	input  logic                     mem_clear_i,

	input  logic                     memreq_val_i,
	output logic                     memreq_rdy_o,
	input  logic [c_req_cnbits-1:0]  memreq_control_i,
	input  logic [c_data_nbits-1:0]  memreq_data_i,
	input  logic                     memreq_domain_i,

	output logic                     memresp_val_o,
	input  logic                     memresp_rdy_i,
	output logic [c_resp_cnbits-1:0] memresp_control_o,
	output logic [c_data_nbits-1:0]  memresp_data_o,
	output logic                     memresp_domain_o
);

	// Queue widths, control plus data plus domain
	localparam int c_req_qnbits = c_req_cnbits + c_data_nbits + 1;
	localparam int c_resp_qnbits = c_resp_cnbits + c_data_nbits + 1;
	localparam int c_idx_nbits = $clog2(p_part_words);

	//----------------------------------------
	// Request side
	//----------------------------------------

	logic                      req_val;
	logic                      resp_enq_rdy;
	logic [c_req_qnbits-1:0]   req_msg;
	logic [c_req_cnbits-1:0]   req_control;
	logic [c_data_nbits-1:0]   req_data;
	logic                      req_domain;
	logic [c_type_nbits-1:0]   req_type_bits;
	mem_type_e                 req_type;
	logic [c_opaque_nbits-1:0] req_opaque;
	logic [c_addr_nbits-1:0]   req_addr;
	logic [c_len_nbits-1:0]    req_len;

	// Internal handshake between the two queues
	logic req_fire;

	mem_queue #(
		.p_msg_nbits (c_req_qnbits),
		.p_bypass    (1'b0)
	) u_req_queue (
		.clk       (clk),
		.reset     (reset),
		.enq_val_i (memreq_val_i),
		.enq_rdy_o (memreq_rdy_o),
		.enq_msg_i ({memreq_control_i, memreq_data_i, memreq_domain_i}),
		.deq_val_o (req_val),
		.deq_rdy_i (resp_enq_rdy),
		.deq_msg_o (req_msg)
	);

	assign {req_control, req_data, req_domain} = req_msg;
	assign {req_type_bits, req_opaque, req_addr, req_len} = req_control;
	assign req_type = mem_type_e'(req_type_bits);
	assign req_fire = req_val && resp_enq_rdy;

	//----------------------------------------
	// Access check and storage
	//----------------------------------------

	logic                    secure;
	logic                    allow;
	logic [c_idx_nbits-1:0]  word_idx;
	logic [c_off_nbits-1:0]  byte_off;
	logic [c_data_nbits-1:0] rdata;

	mem_access_check #(
		.p_part_words (p_part_words)
	) u_access_check (
		.addr_i     (req_addr),
		.mode_i     (mode_i),
		.domain_i   (req_domain),
		.secure_o   (secure),
		.allow_o    (allow),
		.word_idx_o (word_idx),
		.byte_off_o (byte_off)
	);

	mem_partition_array #(
		.p_part_words (p_part_words)
	) u_partition_array (
		.clk        (clk),
		.reset      (reset),
		.clear_i    (mem_clear_i),
		.req_fire_i (req_fire),
		.type_i     (req_type),
		.len_i      (req_len),
		.data_i     (req_data),
		.secure_i   (secure),
		.allow_i    (allow),
		.word_idx_i (word_idx),
		.byte_off_i (byte_off),
		.rdata_o    (rdata)
	);

	//----------------------------------------
	// Response side
	//----------------------------------------

	logic [c_resp_cnbits-1:0] resp_control;
	logic [c_data_nbits-1:0]  resp_data;
	logic [c_resp_qnbits-1:0] resp_msg;

	// Echo type, tag and length
	assign resp_control = {req_type_bits, req_opaque, req_len};

	// Writes answer with zero, reads and atomics with the old data
	assign resp_data = (req_type == mem_write || req_type == mem_write_init) ? '0 : rdata;

	mem_queue #(
		.p_msg_nbits (c_resp_qnbits),
		.p_bypass    (1'b1)
	) u_resp_queue (
		.clk       (clk),
		.reset     (reset),
		.enq_val_i (req_val),
		.enq_rdy_o (resp_enq_rdy),
		.enq_msg_i ({resp_control, resp_data, req_domain}),
		.deq_val_o (memresp_val_o),
		.deq_rdy_i (memresp_rdy_i),
		.deq_msg_o (resp_msg)
	);

	assign {memresp_control_o, memresp_data_o, memresp_domain_o} = resp_msg;

endmodule

//--- test/tb_clock_gen.sv
//----------------------------------------
// Testbench clock, 10 ns period, and active-low
// synchronous reset held for the first five cycles
//----------------------------------------
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk_o,
	output logic reset_o
);

	localparam int c_half_period = 5;

	initial begin
		clk_o = 1'b0;
		forever #(c_half_period) clk_o = ~clk_o;
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		reset_o = 1'b0;
		repeat (5) @(posedge clk_o);
		@(negedge clk_o);
		reset_o = 1'b1;
	end

endmodule

//--- test/test_mem_uni_tb.sv
//----------------------------------------
// Directed tests of the unified test memory against a
// reference model of both partitions, with a watchdog
//----------------------------------------
`timescale 1ns/1ns

module test_mem_uni_tb
	import mem_msg_pkg::*;
();

	localparam int c_part_words = 256;
	localparam int c_bp_reqs = 40;
	// Requests issued by the directed tests other than backpressure
	localparam int c_directed_reqs = 38;
	localparam int c_timeout_cycles = (c_bp_reqs + c_directed_reqs) * 20 + 200;

	logic clk;
	logic reset;
	logic mode;
	logic mem_clear;
	logic memreq_val;
	logic memreq_rdy;
	logic [c_req_cnbits-1:0] memreq_control;
	logic [c_data_nbits-1:0] memreq_data;
	logic memreq_domain;
	logic memresp_val;
	logic memresp_rdy;
	logic [c_resp_cnbits-1:0] memresp_control;
	logic [c_data_nbits-1:0] memresp_data;
	logic memresp_domain;

	// Reference copies of both partitions
	logic [31:0] pub_ref [c_part_words];
	logic [31:0] sec_ref [c_part_words];
	int errors;
	logic [7:0] next_tag;

	tb_clock_gen u_clock_gen (
		.clk_o   (clk),
		.reset_o (reset)
	);

	test_mem_uni #(
		.p_part_words (c_part_words)
	) u_test_mem_uni (
		.clk               (clk),
		.reset             (reset),
		.mode_i            (mode),
		.mem_clear_i       (mem_clear),
		.memreq_val_i      (memreq_val),
		.memreq_rdy_o      (memreq_rdy),
		.memreq_control_i  (memreq_control),
		.memreq_data_i     (memreq_data),
		.memreq_domain_i   (memreq_domain),
		.memresp_val_o     (memresp_val),
		.memresp_rdy_i     (memresp_rdy),
		.memresp_control_o (memresp_control),
		.memresp_data_o    (memresp_data),
		.memresp_domain_o  (memresp_domain)
	);

	//----------------------------------------
	// Reference model
	//----------------------------------------

	task automatic clear_model();
		for (int i = 0; i < c_part_words; i++) begin
			pub_ref[i] = '0;
			sec_ref[i] = '0;
		end
	endtask

	// Expected response data, applies the request to the model
	function automatic logic [31:0] predict(input mem_type_e kind, input logic [31:0] addr,
		input logic [1:0] len, input logic [31:0] data, input logic domain);
		int part;
		int idx;
		int off;
		int nbytes;
		logic allow;
		logic [31:0] old;
		logic [31:0] shifted;
		logic [31:0] upd;
		// Window minus twice the mode, modulo four
		part = (int'(addr[15:14]) - 2 * int'(mode) + 4) % 4;
		allow = (part == 0) || (part == 1 && domain);
		idx = int'(addr[17:2]) % c_part_words;
		off = int'(addr[1:0]);
		old = (part == 1) ? sec_ref[idx] : pub_ref[idx];
		shifted = old >> (8 * off);
		upd = old;
		nbytes = (len == 2'd0) ? 4 : int'(len);
		case (kind)
			mem_write, mem_write_init: begin
				for (int k = 0; k < nbytes; k++) begin
					if (off + k < 4) upd[8*(off+k) +: 8] = data[8*k +: 8];
				end
			end
			mem_amo_add: upd = data + shifted;
			mem_amo_and: upd = data & shifted;
			mem_amo_or:  upd = data | shifted;
			default: ;
		endcase
		if (allow && kind != mem_read) begin
			if (part == 1) sec_ref[idx] = upd;
			else pub_ref[idx] = upd;
		end
		if (!allow || kind == mem_write || kind == mem_write_init) return '0;
		return shifted;
	endfunction

	//----------------------------------------
	// Shared tasks
	//----------------------------------------

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("error: %s expected %08h actual %08h", name, expected, actual);
		end
	endtask

	task automatic check_resp(input string name, input logic [c_resp_cnbits-1:0] exp_ctl,
		input logic [31:0] exp_data, input logic exp_dom, input logic [c_resp_cnbits-1:0] ctl,
		input logic [31:0] data, input logic dom);
		// Control echo holds type, tag and length
		check_value({name, " control"}, 32'(exp_ctl), 32'(ctl));
		check_value({name, " data"}, exp_data, data);
		check_value({name, " domain"}, 32'(exp_dom), 32'(dom));
	endtask

	// Hold the request until a rising edge sees rdy
	task automatic send_req(input mem_type_e kind, input logic [7:0] tag,
		input logic [31:0] addr, input logic [1:0] len, input logic [31:0] data,
		input logic domain);
		@(negedge clk);
		memreq_val = 1'b1;
		memreq_control = {kind, tag, addr, len};
		memreq_data = data;
		memreq_domain = domain;
		while (!memreq_rdy) @(negedge clk);
		@(posedge clk);
		@(negedge clk);
		memreq_val = 1'b0;
	endtask

	// Raise rdy, randomly if asked, and sample on the accepting cycle
	task automatic get_resp(input bit random_rdy, output logic [c_resp_cnbits-1:0] ctl,
		output logic [31:0] data, output logic domain);
		bit done;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			memresp_rdy = random_rdy ? 1'($urandom % 2) : 1'b1;
			done = memresp_val && memresp_rdy;
		end
		ctl = memresp_control;
		data = memresp_data;
		domain = memresp_domain;
		@(posedge clk);
		@(negedge clk);
		memresp_rdy = 1'b0;
	endtask

	// One request and its response, checked against the model
	task automatic do_req(input string name, input mem_type_e kind, input logic [31:0] addr,
		input logic [1:0] len, input logic [31:0] data, input logic domain);
		logic [31:0] expected;
		logic [c_resp_cnbits-1:0] ctl;
		logic [31:0] rdata;
		logic rdom;
		logic [7:0] tag;
		tag = next_tag;
		next_tag++;
		expected = predict(kind, addr, len, data, domain);
		send_req(kind, tag, addr, len, data, domain);
		get_resp(1'b0, ctl, rdata, rdom);
		check_resp(name, {kind, tag, len}, expected, domain, ctl, rdata, rdom);
	endtask

	task automatic set_mode(input logic value);
		@(negedge clk);
		mode = value;
	endtask

	//----------------------------------------
	// Tests
	//----------------------------------------

	task automatic test_public_rw();
		set_mode(1'b0);
		do_req("public_rw", mem_write, 32'h0000_0010, 2'd0, 32'hdead_beef, 1'b0);
		do_req("public_rw", mem_write_init, 32'h0000_0021, 2'd1, 32'h0000_00a5, 1'b1);
		do_req("public_rw", mem_write, 32'h0000_0032, 2'd2, 32'h0000_1234, 1'b0);
		// Only the lowest byte fits at offset 3
		do_req("public_rw", mem_write, 32'h0000_0043, 2'd3, 32'h0056_7890, 1'b0);
		do_req("public_rw", mem_write, 32'h0000_0050, 2'd3, 32'h00ab_cdef, 1'b0);
		do_req("public_rw", mem_write, 32'h0000_0011, 2'd2, 32'h0000_7766, 1'b0);
		do_req("public_rw", mem_read, 32'h0000_0010, 2'd0, 32'h0, 1'b0);
		do_req("public_rw", mem_read, 32'h0000_0020, 2'd0, 32'h0, 1'b1);
		do_req("public_rw", mem_read, 32'h0000_0021, 2'd1, 32'h0, 1'b0);
		do_req("public_rw", mem_read, 32'h0000_0030, 2'd0, 32'h0, 1'b0);
		do_req("public_rw", mem_read, 32'h0000_0040, 2'd0, 32'h0, 1'b0);
		do_req("public_rw", mem_read, 32'h0000_0050, 2'd0, 32'h0, 1'b0);
	endtask

	task automatic test_secure_domain();
		do_req("secure_domain", mem_write, 32'h0000_4010, 2'd0, 32'h5ec0_0001, 1'b1);
		do_req("secure_domain", mem_read, 32'h0000_4010, 2'd0, 32'h0, 1'b1);
		// Domain 0 is turned away but still answered
		do_req("secure_domain", mem_write, 32'h0000_4010, 2'd0, 32'hbad0_bad0, 1'b0);
		do_req("secure_domain", mem_read, 32'h0000_4010, 2'd0, 32'h0, 1'b0);
		do_req("secure_domain", mem_amo_or, 32'h0000_4010, 2'd0, 32'hffff_ffff, 1'b0);
		do_req("secure_domain", mem_read, 32'h0000_4010, 2'd0, 32'h0, 1'b1);
	endtask

	task automatic test_mode_windows();
		set_mode(1'b0);
		do_req("mode_windows", mem_write, 32'h0000_0080, 2'd0, 32'h1111_2222, 1'b0);
		do_req("mode_windows", mem_write, 32'h0000_4080, 2'd0, 32'h3333_4444, 1'b1);
		// Partitions move up to windows 2 and 3
		set_mode(1'b1);
		do_req("mode_windows", mem_read, 32'h0000_8080, 2'd0, 32'h0, 1'b0);
		do_req("mode_windows", mem_read, 32'h0000_c080, 2'd0, 32'h0, 1'b1);
		do_req("mode_windows", mem_read, 32'h0000_0080, 2'd0, 32'h0, 1'b0);
		do_req("mode_windows", mem_read, 32'h0000_4080, 2'd0, 32'h0, 1'b1);
		set_mode(1'b0);
	endtask

	task automatic test_amo();
		mem_type_e ops [3] = '{mem_amo_add, mem_amo_and, mem_amo_or};
		logic [31:0] addr;
		logic [31:0] wexpected;
		logic [31:0] expected;
		logic [c_resp_cnbits-1:0] ctl;
		logic [31:0] rdata;
		logic rdom;
		logic [7:0] wtag;
		logic [7:0] tag;
		for (int i = 0; i < 3; i++) begin
			addr = 32'h0000_0100 + 4 * i;
			// Write response stays in the output queue, so the atomic waits behind it
			wtag = next_tag;
			next_tag++;
			wexpected = predict(mem_write, addr, 2'd0, 32'h0f0f_00ff, 1'b0);
			send_req(mem_write, wtag, addr, 2'd0, 32'h0f0f_00ff, 1'b0);
			tag = next_tag;
			next_tag++;
			expected = predict(ops[i], addr, 2'd0, 32'h3c3c_0101, 1'b0);
			send_req(ops[i], tag, addr, 2'd0, 32'h3c3c_0101, 1'b0);
			// Response port stalled, the atomic sits in the request queue
			repeat (4) begin
				@(negedge clk);
				check_value("amo held valid", 32'h1, 32'(memresp_val));
				check_value("amo held data", wexpected, memresp_data);
				check_value("amo req stalled", 32'h0, 32'(memreq_rdy));
			end
			get_resp(1'b0, ctl, rdata, rdom);
			check_resp("amo write", {mem_write, wtag, 2'd0}, wexpected, 1'b0, ctl, rdata, rdom);
			get_resp(1'b0, ctl, rdata, rdom);
			check_resp("amo", {ops[i], tag, 2'd0}, expected, 1'b0, ctl, rdata, rdom);
			do_req("amo", mem_read, addr, 2'd0, 32'h0, 1'b0);
		end
	endtask

	task automatic test_backpressure();
		logic [c_resp_cnbits-1:0] exp_ctl_q [$];
		logic [31:0] exp_data_q [$];
		logic exp_dom_q [$];
		mem_type_e kind;
		logic [31:0] addr;
		logic [31:0] data;
		logic [1:0] len;
		logic dom;
		logic [c_resp_cnbits-1:0] ctl;
		logic [31:0] rdata;
		logic rdom;
		fork
			begin : sender
				for (int i = 0; i < c_bp_reqs; i++) begin
					kind = ($urandom % 2 == 0) ? mem_read : mem_write;
					// Few words in both partitions, so reads hit earlier writes
					addr = (($urandom % 2) << 14) | (($urandom % 8) << 2) | ($urandom % 4);
					len = 2'($urandom);
					data = $urandom;
					dom = 1'($urandom);
					exp_data_q.push_back(predict(kind, addr, len, data, dom));
					exp_ctl_q.push_back({kind, 8'(i), len});
					exp_dom_q.push_back(dom);
					send_req(kind, 8'(i), addr, len, data, dom);
				end
			end
			begin : receiver
				for (int j = 0; j < c_bp_reqs; j++) begin
					get_resp(1'b1, ctl, rdata, rdom);
					if (exp_ctl_q.size() == 0) begin
						errors++;
						$display("backpressure: a response came with no request outstanding");
					end else begin
						check_resp("backpressure", exp_ctl_q.pop_front(), exp_data_q.pop_front(),
							exp_dom_q.pop_front(), ctl, rdata, rdom);
					end
				end
			end
		join
		// Nothing left over once every response is taken
		repeat (3) @(negedge clk);
		check_value("backpressure extra response", 32'h0, 32'(memresp_val));
	endtask

	task automatic test_clear();
		do_req("clear", mem_write, 32'h0000_0200, 2'd0, 32'hcafe_f00d, 1'b0);
		do_req("clear", mem_write, 32'h0000_4200, 2'd0, 32'hfeed_face, 1'b1);
		@(negedge clk);
		mem_clear = 1'b1;
		@(negedge clk);
		mem_clear = 1'b0;
		clear_model();
		do_req("clear", mem_read, 32'h0000_0200, 2'd0, 32'h0, 1'b0);
		do_req("clear", mem_read, 32'h0000_4200, 2'd0, 32'h0, 1'b1);
		do_req("clear", mem_read, 32'h0000_0010, 2'd0, 32'h0, 1'b0);
	endtask

	//----------------------------------------
	// Main sequence and watchdog
	//----------------------------------------

	initial begin
		void'($urandom(59605));
		errors = 0;
		next_tag = '0;
		mode = 1'b0;
		// Clear runs through reset so storage starts known
		mem_clear = 1'b1;
		memreq_val = 1'b0;
		memreq_control = '0;
		memreq_data = '0;
		memreq_domain = 1'b0;
		memresp_rdy = 1'b0;
		clear_model();
		wait (reset === 1'b1);
		@(negedge clk);
		mem_clear = 1'b0;
		check_value("after reset resp_val", 32'h0, 32'(memresp_val));
		check_value("after reset req_rdy", 32'h1, 32'(memreq_rdy));
		test_public_rw();
		test_secure_domain();
		test_mode_windows();
		test_amo();
		test_backpressure();
		test_clear();
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		repeat (c_timeout_cycles) @(posedge clk);
		$display("Timeout: tests still running after %0d cycles", c_timeout_cycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- sim.f
source/mem_msg_pkg.sv
source/mem_queue.sv
source/mem_access_check.sv
source/mem_partition_array.sv
source/test_mem_uni.sv
test/tb_clock_gen.sv
test/test_mem_uni_tb.sv

//--- Makefile
# Verilator build and run of the test memory testbench
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= test_mem_uni_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
